/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_ifetch -f src.f -o tb_ifetch
	./obj_dir/tb_ifetch | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

/* bench/ifetch_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module ifetch_assert (
	input logic CLK,
	input logic nRST,
	input cpu_types_pkg::wb_m2s_t wb_out,
	input cpu_types_pkg::wb_s2m_t wb_in,
	input logic redirect_valid,
	input logic inst_valid,
	input cpu_types_pkg::word_t inst,
	input logic inst_ready
);

	// stb never without cyc
	a_stb_cyc: assert property (@(posedge CLK) disable iff (!nRST)
		wb_out.stb |-> wb_out.cyc)
		else $error("stb high without cyc");

	// Address and strobe held until ack
	a_adr_hold: assert property (@(posedge CLK) disable iff (!nRST)
		(wb_out.stb && !wb_in.ack) |=> (wb_out.stb && $stable(wb_out.adr)))
		else $error("bus request changed before ack");

	// Stalled decode output stays put unless redirected
	a_inst_hold: assert property (@(posedge CLK) disable iff (!nRST)
		(inst_valid && !inst_ready && !redirect_valid) |=> (inst_valid && $stable(inst)))
		else $error("decode output changed while stalled");

	a_reset_quiet: assert property (@(posedge CLK)
		!nRST |-> (!inst_valid && !wb_out.cyc && !wb_out.stb))
		else $error("valid output high during reset");

endmodule

bind ifetch_top ifetch_assert u_assert (
	.CLK(CLK),
	.nRST(nRST),
	.wb_out(wb_out),
	.wb_in(wb_in),
	.redirect_valid(redirect_valid),
	.inst_valid(inst_valid),
	.inst(inst),
	.inst_ready(inst_ready)
);

`default_nettype wire

/* bench/ifetch_vectors.hex */
// start_pc count ready_pattern exp_hit_count exp_miss_count (counts are running totals)
// ready_pattern bit n gives ready in cycle n, a zero pattern means random ready
// cold pass from reset, then a warm pass over the same range
00000000 00000008 FFFFFFFF 00000004 00000005
00000000 00000008 FFFFFFFF 0000000D 00000005
// index 0 conflict, 0x80 and 0x00 evict each other
00000080 00000001 FFFFFFFF 0000000E 00000006
00000000 00000001 FFFFFFFF 0000000F 00000007
00000080 00000001 FFFFFFFF 00000010 00000008
00000000 00000001 FFFFFFFF 00000011 00000009
// random ready over a new range
00000200 0000000C 00000000 00000017 00000010
// mid-block start, all resident
00000204 00000003 55555555 0000001B 00000010
00001000 00000005 33333333 0000001E 00000013
00000000 00000000 00000000 00000000 00000000

/* bench/tb_ifetch.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_ifetch;

	import cpu_types_pkg::*;

	localparam int MAX_TESTS = 16;
	localparam word_t XOR_PAT = 32'hC0DE0000;

	logic CLK;
	logic nRST;
	logic redirect_valid;
	iaddr_t redirect_pc;
	logic inst_valid;
	word_t inst;
	iaddr_t inst_pc;
	logic inst_ready;
	wb_m2s_t wb_out;
	wb_s2m_t wb_in;
	word_t hit_count;
	word_t miss_count;

	// Five words per test as start PC, count, ready pattern, hits and misses
	logic [31:0] vec [0:MAX_TESTS*5-1];

	integer seed;
	integer fails;
	integer passes;
	integer limit;
	integer wait_left;

	// Reference direct-mapped tag store
	logic [24:0] ref_tag [16];
	logic ref_val [16];
	integer ref_hits;
	integer ref_misses;

	ifetch_top u_dut (
		.CLK(CLK),
		.nRST(nRST),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.inst_valid(inst_valid),
		.inst(inst),
		.inst_pc(inst_pc),
		.inst_ready(inst_ready),
		.wb_out(wb_out),
		.wb_in(wb_in),
		.hit_count(hit_count),
		.miss_count(miss_count)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// Memory model with zero to three wait states per word
	always @(posedge CLK) begin
		#2;
		if (wb_out.cyc && wb_out.stb && !wb_in.ack) begin
			if (wait_left == 0) begin
				wb_in.ack = 1'b1;
				wb_in.dat = wb_out.adr ^ XOR_PAT;
				wait_left = {$random(seed)} % 4;
			end else begin
				wait_left = wait_left - 1;
			end
		end else begin
			wb_in.ack = 1'b0;
		end
	end

	// Walk the reference cache over every word the fetch unit requests
	task automatic predict_counts(input iaddr_t start, input integer n);
		iaddr_t a;
		integer i;
		begin
			a = start;
			for (i = 0; i < n; i++) begin
				if (ref_val[a[6:3]] && (ref_tag[a[6:3]] == a[31:7])) begin
					ref_hits++;
				end else begin
					ref_misses++;
					ref_val[a[6:3]] = 1'b1;
					ref_tag[a[6:3]] = a[31:7];
				end
				a = a + 32'd4;
			end
		end
	endtask

	task automatic run_test(input integer t);
		iaddr_t start;
		integer count;
		logic [31:0] pattern;
		integer got;
		integer cyc;
		integer errs;
		iaddr_t exp_pc;
		begin
			start = vec[t*5];
			count = vec[t*5+1];
			pattern = vec[t*5+2];
			errs = 0;
			got = 0;
			cyc = 0;
			exp_pc = start;
			// Later tests start with a redirect that drops the held word
			if (t > 0) begin
				redirect_valid = 1'b1;
				redirect_pc = start;
				@(posedge CLK);
				#2;
				redirect_valid = 1'b0;
			end
			while (got < count) begin
				if (pattern == 32'd0)
					inst_ready = 1'($random(seed));
				else
					inst_ready = pattern[cyc % 32];
				@(negedge CLK);
				if (inst_valid && inst_ready) begin
					if (inst_pc !== exp_pc) begin
						$display("FAIL %0t: inst_pc %h, expected %h", $time, inst_pc, exp_pc);
						errs++;
					end
					if (inst !== (exp_pc ^ XOR_PAT)) begin
						$display("FAIL %0t: inst %h at pc %h, expected %h", $time, inst,
							exp_pc, exp_pc ^ XOR_PAT);
						errs++;
					end
					exp_pc = exp_pc + 32'd4;
					got++;
				end
				@(posedge CLK);
				#2;
				cyc++;
			end
			// One more word is prefetched into the output register
			inst_ready = 1'b0;
			@(negedge CLK);
			while (!inst_valid) begin
				@(negedge CLK);
			end
			predict_counts(start, count + 1);
			if ((ref_hits != vec[t*5+3]) || (ref_misses != vec[t*5+4])) begin
				$display("FAIL %0t: model counts %0d/%0d disagree with vectors %0d/%0d",
					$time, ref_hits, ref_misses, vec[t*5+3], vec[t*5+4]);
				errs++;
			end
			if ((hit_count !== vec[t*5+3]) || (miss_count !== vec[t*5+4])) begin
				$display("FAIL %0t: counts hit %0d miss %0d, expected %0d %0d", $time,
					hit_count, miss_count, vec[t*5+3], vec[t*5+4]);
				errs++;
			end
			@(posedge CLK);
			#2;
			if (errs == 0) begin
				passes++;
				$display("test %0d at pc %h: passed", t, start);
			end else begin
				fails++;
				$display("test %0d at pc %h: failed with %0d errors", t, start, errs);
			end
		end
	endtask

	// Watchdog with a limit taken from the instruction counts
	initial begin
		wait (limit != 0);
		repeat (limit) @(posedge CLK);
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("Test failed");
		$finish;
	end

	initial begin
		integer t;
		integer sum;
		seed = 32'h4709;
		fails = 0;
		passes = 0;
		limit = 0;
		wait_left = 0;
		ref_hits = 0;
		ref_misses = 0;
		for (t = 0; t < 16; t++) begin
			ref_val[t] = 1'b0;
			ref_tag[t] = '0;
		end
		for (t = 0; t < MAX_TESTS * 5; t++) begin
			vec[t] = '0;
		end
		nRST = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		inst_ready = 1'b0;
		wb_in = '0;
		$readmemh("bench/ifetch_vectors.hex", vec);
		sum = 0;
		for (t = 0; t < MAX_TESTS; t++) begin
			sum = sum + vec[t*5+1];
		end
		limit = sum * 40 + 1000;
		repeat (10) @(posedge CLK);
		#2;
		nRST = 1'b1;
		// A zero count ends the list
		t = 0;
		while ((t < MAX_TESTS) && (vec[t*5+1] != 0)) begin
			run_test(t);
			t++;
		end
		$display("passed %0d, failed %0d", passes, fails);
		if (fails == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/cpu_types_pkg.sv */
`default_nettype none

package cpu_types_pkg;

	// Basic machine word and byte address
	typedef logic [31:0] word_t;
	typedef logic [31:0] iaddr_t;

	// Instruction cache geometry
	// 16 sets, 2 words per block, 4 bytes per word
	localparam int IIDX_W = 4;
	localparam int IBLK_W = 1;
	localparam int IBYT_W = 2;
	localparam int ITAG_W = 32 - IIDX_W - IBLK_W - IBYT_W;

	// Cache view of an instruction address
	typedef struct packed {
		logic [ITAG_W-1:0] tag;
		logic [IIDX_W-1:0] idx;
		logic [IBLK_W-1:0] blkoff;
		logic [IBYT_W-1:0] bytoff;
	} icachef_t;

	// Same 32 bits read as a plain address or as cache fields
	typedef union packed {
		iaddr_t raw;
		icachef_t fields;
	} icache_addr_u;

	// Fetch unit to cache
	typedef struct packed {
		logic valid;
		icache_addr_u addr;
	} fetch_req_t;

	// Cache answer to the fetch unit within the same cycle
	typedef struct packed {
		logic hit;
		word_t inst;
	} fetch_rsp_t;

	// Cache request to the bus master held for a whole block
	typedef struct packed {
		logic valid;
		iaddr_t base;
	} refill_req_t;

	// Bus master pulses one word at a time to the cache
	typedef struct packed {
		logic valid;
		logic last;
		word_t data;
	} refill_rsp_t;

	// Wishbone classic master outputs
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		iaddr_t adr;
		logic [3:0] sel;
		word_t dat;
	} wb_m2s_t;

	// Wishbone classic slave outputs
	typedef struct packed {
		logic ack;
		word_t dat;
	} wb_s2m_t;

endpackage

`default_nettype wire

/* rtl/fetch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_unit #(
	parameter cpu_types_pkg::iaddr_t RESET_PC = '0
) (
	input logic CLK,
	input logic nRST,
	// Redirect from later stages
	input logic redirect_valid,
	input cpu_types_pkg::iaddr_t redirect_pc,
	// Cache port
	output cpu_types_pkg::fetch_req_t req,
	input cpu_types_pkg::fetch_rsp_t rsp,
	// Decode port
	output logic inst_valid,
	output cpu_types_pkg::word_t inst,
	output cpu_types_pkg::iaddr_t inst_pc,
	input logic inst_ready
);

	import cpu_types_pkg::*;

	// Program counter of the next request
	iaddr_t pc;

	// One-entry output register toward decode
	logic out_valid;
	word_t out_inst;
	iaddr_t out_pc;

	// Output slot free this cycle
	logic drain;
	// Cache hit accepted into the output slot
	logic take;

	// Slot is empty or decode takes it now
	assign drain = !out_valid || inst_ready;

	// No request while a redirect is pending since the old PC is stale
	assign req.valid = drain && !redirect_valid;
	assign req.addr.raw = pc;

	assign take = req.valid && rsp.hit;

	// PC and output valid
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			pc <= RESET_PC;
			out_valid <= 1'b0;
		end else if (redirect_valid) begin
			// Drop held instruction and restart at new PC
			pc <= redirect_pc;
			out_valid <= 1'b0;
		end else if (take) begin
			pc <= pc + 32'd4;
			out_valid <= 1'b1;
		end else if (out_valid && inst_ready) begin
			// Drained with nothing to replace it
			out_valid <= 1'b0;
		end
	end

	// Instruction and its PC
	always_ff @(posedge CLK) begin
		if (take) begin
			out_inst <= rsp.inst;
			out_pc <= pc;
		end
	end

	assign inst_valid = out_valid;
	assign inst = out_inst;
	assign inst_pc = out_pc;

endmodule

`default_nettype wire

/* rtl/icache.sv */
`timescale 1ns/100ps
`default_nettype none

module icache #(
	parameter int SETS = 16,
	parameter int WORDS_PER_BLK = 2
) (
	input logic CLK,
	input logic nRST,
	// Fetch unit side
	input cpu_types_pkg::fetch_req_t req,
	output cpu_types_pkg::fetch_rsp_t rsp,
	// Bus master side
	output cpu_types_pkg::refill_req_t refill,
	input cpu_types_pkg::refill_rsp_t fill,
	// Statistics
	output cpu_types_pkg::word_t hit_count,
	output cpu_types_pkg::word_t miss_count
);

	import cpu_types_pkg::*;

	typedef enum logic {
		IDLE,
		REFILL
	} state_t;

	state_t state;

	// Cache arrays
	logic [SETS-1:0] valid_q;
	logic [ITAG_W-1:0] tag_mem [SETS];
	word_t data_mem [SETS][WORDS_PER_BLK];

	// Request address split into fields
	icache_addr_u addr;

	// Block under refill as captured on the miss
	logic [ITAG_W-1:0] fill_tag;
	logic [IIDX_W-1:0] fill_idx;
	logic [IBLK_W-1:0] fill_off;
	icache_addr_u base_u;

	logic tag_match;
	logic hit;
	logic miss;

	// Set once a refill starts and cleared by the next hit
	logic refilled;

	word_t hit_cnt;
	word_t miss_cnt;

	assign addr = req.addr;

	// Tag compare against the indexed set
	assign tag_match = valid_q[addr.fields.idx] && (tag_mem[addr.fields.idx] == addr.fields.tag);

	// Only answer in idle
	assign hit = req.valid && (state == IDLE) && tag_match;
	assign miss = req.valid && (state == IDLE) && !tag_match;

	assign rsp.hit = hit;
	assign rsp.inst = data_mem[addr.fields.idx][addr.fields.blkoff];

	// Block base address with zero offsets
	always_comb begin
		base_u = '0;
		base_u.fields.tag = fill_tag;
		base_u.fields.idx = fill_idx;
	end

	// Held for the whole refill and dropped after the last word
	assign refill.valid = (state == REFILL);
	assign refill.base = base_u.raw;

	// Refill FSM, valid bits and counters
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
			valid_q <= '0;
			fill_tag <= '0;
			fill_idx <= '0;
			fill_off <= '0;
			refilled <= 1'b0;
			hit_cnt <= '0;
			miss_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (miss) begin
						// Invalidate the victim while it is overwritten
						state <= REFILL;
						valid_q[addr.fields.idx] <= 1'b0;
						fill_tag <= addr.fields.tag;
						fill_idx <= addr.fields.idx;
						fill_off <= '0;
						refilled <= 1'b1;
						miss_cnt <= miss_cnt + 32'd1;
					end else if (hit) begin
						// First hit after a refill is the missed word itself
						if (!refilled) begin
							hit_cnt <= hit_cnt + 32'd1;
						end
						refilled <= 1'b0;
					end
				end
				REFILL: begin
					if (fill.valid) begin
						fill_off <= fill_off + 1'b1;
						if (fill.last) begin
							valid_q[fill_idx] <= 1'b1;
							state <= IDLE;
						end
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Array writes in word order with the tag on the last one
	always_ff @(posedge CLK) begin
		if ((state == REFILL) && fill.valid) begin
			data_mem[fill_idx][fill_off] <= fill.data;
			if (fill.last) begin
				tag_mem[fill_idx] <= fill_tag;
			end
		end
	end

	assign hit_count = hit_cnt;
	assign miss_count = miss_cnt;

endmodule

`default_nettype wire

/* rtl/ifetch_top.sv */
`timescale 1ns/100ps
`default_nettype none

module ifetch_top #(
	parameter int SETS = 16,
	parameter int WORDS_PER_BLK = 2
) (
	input logic CLK,
	input logic nRST,
	// Redirect port
	input logic redirect_valid,
	input cpu_types_pkg::iaddr_t redirect_pc,
	// Decode port
	output logic inst_valid,
	output cpu_types_pkg::word_t inst,
	output cpu_types_pkg::iaddr_t inst_pc,
	input logic inst_ready,
	// Memory bus
	output cpu_types_pkg::wb_m2s_t wb_out,
	input cpu_types_pkg::wb_s2m_t wb_in,
	// Statistics
	output cpu_types_pkg::word_t hit_count,
	output cpu_types_pkg::word_t miss_count
);

	import cpu_types_pkg::*;

	// Parameters must agree with the fixed package field layout
	if ((SETS != (1 << IIDX_W)) || (WORDS_PER_BLK != (1 << IBLK_W))) begin : g_geom_check
		$fatal(1, "icache geometry does not match cpu_types_pkg field widths");
	end

	fetch_req_t req;
	fetch_rsp_t rsp;
	refill_req_t refill;
	refill_rsp_t fill;

	// PC, output register, back-pressure
	fetch_unit u_fetch (
		.CLK(CLK),
		.nRST(nRST),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.req(req),
		.rsp(rsp),
		.inst_valid(inst_valid),
		.inst(inst),
		.inst_pc(inst_pc),
		.inst_ready(inst_ready)
	);

	// Direct-mapped array, hit check, refill FSM
	icache #(
		.SETS(SETS),
		.WORDS_PER_BLK(WORDS_PER_BLK)
	) u_icache (
		.CLK(CLK),
		.nRST(nRST),
		.req(req),
		.rsp(rsp),
		.refill(refill),
		.fill(fill),
		.hit_count(hit_count),
		.miss_count(miss_count)
	);

	// Block refill over Wishbone
	imem_bus_master #(
		.SETS(SETS),
		.WORDS_PER_BLK(WORDS_PER_BLK)
	) u_bus (
		.CLK(CLK),
		.nRST(nRST),
		.refill(refill),
		.fill(fill),
		.wb_out(wb_out),
		.wb_in(wb_in)
	);

endmodule

`default_nettype wire

/* rtl/imem_bus_master.sv */
`timescale 1ns/100ps
`default_nettype none

module imem_bus_master #(
	parameter int SETS = 16,
	parameter int WORDS_PER_BLK = 2
) (
	input logic CLK,
	input logic nRST,
	// Cache side
	input cpu_types_pkg::refill_req_t refill,
	output cpu_types_pkg::refill_rsp_t fill,
	// Wishbone classic
	output cpu_types_pkg::wb_m2s_t wb_out,
	input cpu_types_pkg::wb_s2m_t wb_in
);

	import cpu_types_pkg::*;

	// Word counter width of at least one bit
	localparam int CNT_W = (WORDS_PER_BLK > 1) ? $clog2(WORDS_PER_BLK) : 1;

	typedef enum logic [1:0] {
		BM_IDLE,
		BM_BUS,
		BM_GAP
	} bm_state_t;

	bm_state_t state;
	logic [CNT_W-1:0] cnt;
	logic last_word;

	// Registered fill pulse
	logic fill_valid;
	logic fill_last;
	word_t fill_data;

	assign last_word = (cnt == CNT_W'(WORDS_PER_BLK - 1));

	// Bus state and word counter
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= BM_IDLE;
			cnt <= '0;
			fill_valid <= 1'b0;
			fill_last <= 1'b0;
		end else begin
			fill_valid <= 1'b0;
			case (state)
				BM_IDLE: begin
					if (refill.valid) begin
						state <= BM_BUS;
					end
				end
				BM_BUS: begin
					// Address held until ack
					if (wb_in.ack) begin
						fill_valid <= 1'b1;
						fill_last <= last_word;
						cnt <= last_word ? '0 : cnt + CNT_W'(1);
						state <= BM_GAP;
					end
				end
				BM_GAP: begin
					// One idle cycle between words
					state <= fill_last ? BM_IDLE : BM_BUS;
				end
				default: begin
					state <= BM_IDLE;
				end
			endcase
		end
	end

	// Captured read data
	always_ff @(posedge CLK) begin
		if ((state == BM_BUS) && wb_in.ack) begin
			fill_data <= wb_in.dat;
		end
	end

	assign fill.valid = fill_valid;
	assign fill.last = fill_last;
	assign fill.data = fill_data;

	// Single read per word at base plus four times the count
	assign wb_out.cyc = (state == BM_BUS);
	assign wb_out.stb = (state == BM_BUS);
	assign wb_out.we = 1'b0;
	assign wb_out.adr = refill.base + (iaddr_t'(cnt) << 2);
	assign wb_out.sel = 4'hF;
	assign wb_out.dat = '0;

endmodule

`default_nettype wire

/* src.f */
rtl/cpu_types_pkg.sv
rtl/fetch_unit.sv
rtl/icache.sv
rtl/imem_bus_master.sv
rtl/ifetch_top.sv
bench/ifetch_assert.sv
bench/tb_ifetch.sv
